//--- include/fpu_params.svh
// Sizing constants for the half-precision arithmetic unit.
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// Half-precision field layout.
`define FP16_EXPW 5
`define FP16_FRACW 10
`define FP16_BIAS 15
`define FP16_EXP_MAX 30

// Canonical quiet NaN.
`define FP16_QNAN 16'h7E00

// Flow control and iteration sizing.
`define FPU_REQ_DEPTH 4
`define FPU_RES_CREDITS 4
`define FPU_MUL_STEPS 11

`endif

//--- rtl/fpuPkg.sv
// Data types shared across the fp16 arithmetic unit.
`include "fpu_params.svh"

package fpuPkg;

  typedef struct packed {
    logic                    sign;
    logic [`FP16_EXPW-1:0]   exp;
    logic [`FP16_FRACW-1:0]  frac;
  } fp16_t;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2
  } fpuOp_t;

  typedef struct packed {
    fpuOp_t      op;
    fp16_t       a;
    fp16_t       b;
    logic [3:0]  tag;
  } fpuReq_t;

  typedef struct packed {
    logic overflow;
    logic underflow;
    logic inexact;
  } opStatusFlag_t;

  // Value is intPart.frac scaled by 2^(exp - bias), exp is at least 1.
  typedef struct packed {
    logic                        sign;
    logic [1:0]                  intPart;
    logic [2*`FP16_FRACW+1:0]    frac;
    logic [`FP16_EXPW-1:0]       exp;
    logic                        sticky;
    logic                        ovf;
  } fpuUnnorm_t;

  typedef struct packed {
    logic   valid;
    fp16_t  value;
  } fpuSpecial_t;

  typedef struct packed {
    fp16_t          result;
    opStatusFlag_t  flags;
    logic [3:0]     tag;
  } fpuRes_t;

endpackage

//--- rtl/fpuReqQueue.sv
// Request FIFO that hands back one upstream credit for each entry popped.
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpuReqQueue
  import fpuPkg::*;
  (
  input  logic     clk,
  input  logic     rst,
  input  logic     reqValid,
  input  fpuReq_t  req,
  input  logic     pop,
  output fpuReq_t  head,
  output logic     notEmpty,
  output logic     reqCredit
  );

  localparam int PtrW = $clog2(`FPU_REQ_DEPTH);

  fpuReq_t         mem [`FPU_REQ_DEPTH];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [PtrW:0]   count;
  logic            doWrite;
  logic            doRead;

  // Upstream holds a credit per write, the full check is only a guard.
  assign doWrite = reqValid && (count != (PtrW+1)'(`FPU_REQ_DEPTH));
  assign doRead = pop && notEmpty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) wrPtr <= wrPtr + 1'b1;
      if (doRead) rdPtr <= rdPtr + 1'b1;
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (doWrite) mem[wrPtr] <= req;
  end

  assign head = mem[rdPtr];
  assign notEmpty = (count != '0);
  // One credit back per popped entry.
  assign reqCredit = doRead;

endmodule

//--- rtl/fpuCreditCounter.sv
// Downstream credit counter gating result delivery.
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpuCreditCounter (
  input  logic clk,
  input  logic rst,
  input  logic consume,
  input  logic resCredit,
  output logic creditAvail
  );

  localparam int CntW = $clog2(`FPU_RES_CREDITS + 1);

  logic [CntW-1:0] count;

  // Send and return together cancel out.
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= CntW'(`FPU_RES_CREDITS);
    end else if (consume && !resCredit && (count != '0)) begin
      count <= count - 1'b1;
    end else if (resCredit && !consume && (count != CntW'(`FPU_RES_CREDITS))) begin
      count <= count + 1'b1;
    end
  end

  assign creditAvail = (count != '0);

endmodule

//--- rtl/fpuAddSub.sv
// Sort, align and add path for fp16 add and subtract.
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpuAddSub
  import fpuPkg::*;
  (
  input  fp16_t        a,
  input  fp16_t        b,
  input  logic         sub,
  output fpuUnnorm_t   unnorm,
  output fpuSpecial_t  special
  );

  localparam int FW = `FP16_FRACW;
  localparam int XW = 2*FW + 2;
  localparam int PadW = XW - FW;

  fp16_t                 bEff;
  fp16_t                 opL;
  fp16_t                 opS;
  logic [`FP16_EXPW-1:0] expL;
  logic [`FP16_EXPW-1:0] expS;
  logic [`FP16_EXPW-1:0] diff;
  logic [XW:0]           sigL;
  logic [XW:0]           sigS;
  logic [XW:0]           sigAligned;
  logic [XW:0]           lost;
  logic [XW+1:0]         sum;
  logic                  sticky;
  logic                  effSub;
  logic                  aNan;
  logic                  bNan;
  logic                  aInf;
  logic                  bInf;

  always_comb begin
    bEff = b;
    bEff.sign = b.sign ^ sub;
    // Larger magnitude goes first.
    if ({a.exp, a.frac} >= {bEff.exp, bEff.frac}) begin
      opL = a;
      opS = bEff;
    end else begin
      opL = bEff;
      opS = a;
    end
    // Subnormals sit at exponent 1.
    expL = (opL.exp == '0) ? `FP16_EXPW'(1) : opL.exp;
    expS = (opS.exp == '0) ? `FP16_EXPW'(1) : opS.exp;
    diff = expL - expS;
    sigL = {opL.exp != '0, opL.frac, PadW'(0)};
    sigS = {opS.exp != '0, opS.frac, PadW'(0)};
    {sigAligned, lost} = {sigS, (XW+1)'(0)} >> diff;
    sticky = |lost;
    effSub = opL.sign ^ opS.sign;
    // Sticky jammed into the LSB keeps subtraction rounding honest.
    if (effSub) begin
      sum = {1'b0, sigL} - {1'b0, sigAligned | (XW+1)'(sticky)};
    end else begin
      sum = {1'b0, sigL} + {1'b0, sigAligned | (XW+1)'(sticky)};
    end
    unnorm.sign = (effSub && (sum == '0)) ? 1'b0 : opL.sign;
    unnorm.intPart = sum[XW+1:XW];
    unnorm.frac = sum[XW-1:0];
    unnorm.exp = expL;
    unnorm.sticky = sticky;
    unnorm.ovf = 1'b0;

    aNan = (a.exp == '1) && (a.frac != '0);
    bNan = (b.exp == '1) && (b.frac != '0);
    aInf = (a.exp == '1) && (a.frac == '0);
    bInf = (b.exp == '1) && (b.frac == '0);
    special.valid = aNan | bNan | aInf | bInf;
    if (aNan || bNan || (aInf && bInf && (a.sign != bEff.sign))) begin
      special.value = `FP16_QNAN;
    end else if (aInf) begin
      special.value = a;
    end else begin
      special.value = bEff;
    end
  end

endmodule

//--- rtl/fpuMulIter.sv
// Iterative shift-and-add significand multiplier with exponent sum.
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpuMulIter
  import fpuPkg::*;
  (
  input  logic         clk,
  input  logic         rst,
  input  logic         mulStart,
  input  logic         mulStep,
  input  fp16_t        a,
  input  fp16_t        b,
  output fpuUnnorm_t   unnorm,
  output fpuSpecial_t  special
  );

  localparam int EW = `FP16_EXPW;
  localparam int SigW = `FP16_FRACW + 1;
  localparam int ProdW = 2*SigW;
  localparam int ExtW = ProdW + 2;

  logic [SigW-1:0] mcand;
  logic [SigW-1:0] mplier;
  logic [ProdW-1:0] acc;
  logic [EW:0]     rawSum;
  logic [EW-1:0]   expReg;
  logic [EW-1:0]   shiftReg;
  logic            prodSign;
  logic            ovfReg;
  logic [ExtW-1:0] prodShifted;
  logic [ExtW-1:0] lost;
  logic            aNan;
  logic            bNan;
  logic            aInf;
  logic            bInf;
  logic            aZero;
  logic            bZero;

  // Biased sum of effective exponents, subnormals count as 1.
  assign rawSum = (a.exp == '0 ? (EW+1)'(1) : (EW+1)'(a.exp))
                + (b.exp == '0 ? (EW+1)'(1) : (EW+1)'(b.exp));

  // MSB-first: shift the partial sum, add the multiplicand on a set bit.
  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
      mplier <= '0;
    end else if (mulStart) begin
      acc <= '0;
      mplier <= {b.exp != '0, b.frac};
    end else if (mulStep) begin
      acc <= {acc[ProdW-2:0], 1'b0} + (mplier[SigW-1] ? ProdW'(mcand) : ProdW'(0));
      mplier <= {mplier[SigW-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (mulStart) begin
      mcand <= {a.exp != '0, a.frac};
      prodSign <= a.sign ^ b.sign;
      ovfReg <= (rawSum > (EW+1)'(`FP16_EXP_MAX + `FP16_BIAS));
      // Below the normal range the product is pre-shifted to exponent 1.
      if (rawSum <= (EW+1)'(`FP16_BIAS)) begin
        expReg <= EW'(1);
        shiftReg <= EW'((EW+1)'(`FP16_BIAS + 1) - rawSum);
      end else begin
        expReg <= EW'(rawSum - (EW+1)'(`FP16_BIAS));
        shiftReg <= '0;
      end
    end
  end

  assign {prodShifted, lost} = {acc, 2'b00, ExtW'(0)} >> shiftReg;

  assign unnorm.sign = prodSign;
  assign unnorm.intPart = prodShifted[ExtW-1:ExtW-2];
  assign unnorm.frac = prodShifted[ExtW-3:0];
  assign unnorm.exp = expReg;
  assign unnorm.sticky = |lost;
  assign unnorm.ovf = ovfReg;

  always_comb begin
    aNan = (a.exp == '1) && (a.frac != '0);
    bNan = (b.exp == '1) && (b.frac != '0);
    aInf = (a.exp == '1) && (a.frac == '0);
    bInf = (b.exp == '1) && (b.frac == '0);
    aZero = (a.exp == '0) && (a.frac == '0);
    bZero = (b.exp == '0) && (b.frac == '0);
    special.valid = aNan | bNan | aInf | bInf;
    if (aNan || bNan || (aInf && bZero) || (bInf && aZero)) begin
      special.value = `FP16_QNAN;
    end else begin
      special.value = {a.sign ^ b.sign, {EW{1'b1}}, `FP16_FRACW'(0)};
    end
  end

endmodule

//--- rtl/fpuNormalizer16.sv
// Normalizes, rounds to nearest-even and flags fp16 results.
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpuNormalizer16
  import fpuPkg::*;
  (
  input  fpuUnnorm_t     unnorm,
  output fp16_t          normOut,
  output opStatusFlag_t  opStatusFlags
  );

  localparam int FW = `FP16_FRACW;
  localparam int XW = 2*FW + 2;
  localparam int SigW = XW + 2;
  localparam int EW = `FP16_EXPW + 1;
  localparam int GuardBit = XW - FW - 1;
  localparam int LzcW = $clog2(XW + 2);

  logic [LzcW-1:0] lzc;
  logic [LzcW-1:0] need;
  logic [LzcW-1:0] limit;
  logic [LzcW-1:0] shamt;
  logic [SigW-1:0] sig;
  logic [SigW-1:0] normSig;
  logic [EW-1:0]   normExp;
  logic [EW-1:0]   finalExp;
  logic [FW+1:0]   rounded;
  logic [FW-1:0]   fracOut;
  logic            stickyAll;
  logic            guard;
  logic            roundBit;
  logic            roundUp;
  logic            overflow;

  always_comb begin
    sig = {unnorm.intPart, unnorm.frac};
    // Leading zeros of the fraction, XW when it is all zero.
    lzc = LzcW'(XW);
    for (int i = 0; i < XW; i++) begin
      if (unnorm.frac[i]) lzc = LzcW'(XW - 1 - i);
    end
    need = lzc + 1'b1;
    limit = LzcW'(unnorm.exp - 1'b1);
    shamt = '0;
    stickyAll = unnorm.sticky;
    if (unnorm.intPart > 2'd1) begin
      normSig = sig >> 1;
      normExp = EW'(unnorm.exp) + 1'b1;
      stickyAll = unnorm.sticky | sig[0];
    end else if (unnorm.intPart == 2'd0) begin
      // Stop at exponent 1, anything left over stays subnormal.
      shamt = (need < limit) ? need : limit;
      normSig = sig << shamt;
      normExp = EW'(unnorm.exp) - EW'(shamt);
    end else begin
      normSig = sig;
      normExp = EW'(unnorm.exp);
    end

    guard = normSig[GuardBit];
    roundBit = normSig[GuardBit-1];
    stickyAll = stickyAll | (|normSig[GuardBit-2:0]);
    roundUp = guard & (roundBit | stickyAll | normSig[GuardBit+1]);
    rounded = {1'b0, normSig[XW:GuardBit+1]} + (FW+2)'(roundUp);

    // Carry out of the significand bumps the exponent.
    if (rounded[FW+1]) begin
      finalExp = normExp + 1'b1;
      fracOut = '0;
    end else begin
      finalExp = rounded[FW] ? normExp : '0;
      fracOut = rounded[FW-1:0];
    end

    overflow = unnorm.ovf || (finalExp > EW'(`FP16_EXP_MAX));
    if (overflow) begin
      normOut = {unnorm.sign, {(EW-1){1'b1}}, FW'(0)};
    end else begin
      normOut = {unnorm.sign, finalExp[EW-2:0], fracOut};
    end
    opStatusFlags.overflow = overflow;
    opStatusFlags.underflow = !overflow && (finalExp == '0) && (fracOut != '0);
    opStatusFlags.inexact = overflow | guard | roundBit | stickyAll;
  end

endmodule

//--- rtl/fpuSequencer.sv
// Control FSM that issues requests to the add or multiply path and sends results.
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpuSequencer
  import fpuPkg::*;
  (
  input  logic           clk,
  input  logic           rst,
  input  logic           notEmpty,
  input  fpuReq_t        head,
  input  fp16_t          normOut,
  input  opStatusFlag_t  opStatusFlags,
  input  fpuSpecial_t    addSpecial,
  input  fpuSpecial_t    mulSpecial,
  input  logic           creditAvail,
  output logic           pop,
  output fpuReq_t        curReq,
  output logic           selMul,
  output logic           mulStart,
  output logic           mulStep,
  output logic           resValid,
  output fpuRes_t        res
  );

  localparam int IterW = $clog2(`FPU_MUL_STEPS + 1);

  typedef enum logic [1:0] {ST_IDLE, ST_ADD, ST_MUL, ST_SEND} seqState_t;

  seqState_t        state;
  fpuReq_t          reqReg;
  logic [IterW-1:0] iterCnt;
  logic             mulDone;
  fpuSpecial_t      special;
  fpuRes_t          resNext;

  assign pop = (state == ST_IDLE) && notEmpty;
  // Head feeds the multiplier directly so it loads in the pop cycle.
  assign curReq = (state == ST_IDLE) ? head : reqReg;
  assign mulStart = pop && (head.op == MUL);
  assign selMul = (state == ST_MUL);
  assign mulDone = (iterCnt == IterW'(`FPU_MUL_STEPS));
  assign mulStep = selMul && !mulDone;
  assign resValid = (state == ST_SEND) && creditAvail;
  assign special = selMul ? mulSpecial : addSpecial;

  always_comb begin
    resNext.tag = reqReg.tag;
    if (special.valid) begin
      resNext.result = special.value;
      resNext.flags = '0;
    end else begin
      resNext.result = normOut;
      resNext.flags = opStatusFlags;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      iterCnt <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (notEmpty) begin
            state <= (head.op == MUL) ? ST_MUL : ST_ADD;
            iterCnt <= '0;
          end
        end
        ST_ADD:  state <= ST_SEND;
        ST_MUL: begin
          if (mulDone) state <= ST_SEND;
          else iterCnt <= iterCnt + 1'b1;
        end
        ST_SEND: begin
          // Hold the result until downstream has room.
          if (creditAvail) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) reqReg <= head;
    if ((state == ST_ADD) || (selMul && mulDone)) res <= resNext;
  end

endmodule

//--- rtl/fpuTop.sv
// Top level of the fp16 add, subtract and multiply unit.
`timescale 1ns/1ps

module fpuTop
  import fpuPkg::*;
  (
  input  logic     clk,
  input  logic     rst,
  input  logic     reqValid,
  input  fpuReq_t  req,
  output logic     reqCredit,
  output logic     resValid,
  output fpuRes_t  res,
  input  logic     resCredit
  );

  fpuReq_t       head;
  fpuReq_t       curReq;
  logic          notEmpty;
  logic          pop;
  logic          selMul;
  logic          mulStart;
  logic          mulStep;
  logic          creditAvail;
  fpuUnnorm_t    addUnnorm;
  fpuUnnorm_t    mulUnnorm;
  fpuUnnorm_t    normIn;
  fpuSpecial_t   addSpecial;
  fpuSpecial_t   mulSpecial;
  fp16_t         normOut;
  opStatusFlag_t opStatusFlags;

  // Path select into the shared normalizer.
  assign normIn = selMul ? mulUnnorm : addUnnorm;

  fpuReqQueue i_fpuReqQueue (
    .clk       (clk),
    .rst       (rst),
    .reqValid  (reqValid),
    .req       (req),
    .pop       (pop),
    .head      (head),
    .notEmpty  (notEmpty),
    .reqCredit (reqCredit)
  );

  fpuSequencer i_fpuSequencer (
    .clk           (clk),
    .rst           (rst),
    .notEmpty      (notEmpty),
    .head          (head),
    .normOut       (normOut),
    .opStatusFlags (opStatusFlags),
    .addSpecial    (addSpecial),
    .mulSpecial    (mulSpecial),
    .creditAvail   (creditAvail),
    .pop           (pop),
    .curReq        (curReq),
    .selMul        (selMul),
    .mulStart      (mulStart),
    .mulStep       (mulStep),
    .resValid      (resValid),
    .res           (res)
  );

  fpuAddSub i_fpuAddSub (
    .a       (curReq.a),
    .b       (curReq.b),
    .sub     (curReq.op == SUB),
    .unnorm  (addUnnorm),
    .special (addSpecial)
  );

  fpuMulIter i_fpuMulIter (
    .clk      (clk),
    .rst      (rst),
    .mulStart (mulStart),
    .mulStep  (mulStep),
    .a        (curReq.a),
    .b        (curReq.b),
    .unnorm   (mulUnnorm),
    .special  (mulSpecial)
  );

  fpuNormalizer16 i_fpuNormalizer16 (
    .unnorm        (normIn),
    .normOut       (normOut),
    .opStatusFlags (opStatusFlags)
  );

  fpuCreditCounter i_fpuCreditCounter (
    .clk         (clk),
    .rst         (rst),
    .consume     (resValid),
    .resCredit   (resCredit),
    .creditAvail (creditAvail)
  );

endmodule

//--- verif/fpuTb.sv
// Directed testbench for the fp16 add, subtract and multiply unit.
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpuTb
  import fpuPkg::*;
  ();

  localparam int ResetCycles = 8;
  localparam int CyclesPerReq = 20;
  localparam int MarginCycles = 200;
  localparam int HoldCycles = 40;

  logic    clk;
  logic    rst;
  logic    reqValid;
  fpuReq_t req;
  logic    reqCredit;
  logic    resValid;
  fpuRes_t res;
  logic    resCredit = 1'b0;

  fpuRes_t    expQ[$];
  fpuRes_t    gotQ[$];
  int         checkIdx = 0;
  int         sentCnt = 0;
  int         creditsBack = 0;
  int         outstanding = 0;
  int         errCnt = 0;
  int         checkCnt = 0;
  int         cycleCnt = 0;
  int         seed = 32'hd2b1ccbd;
  logic       returnEnable = 1'b0;
  logic       giveBack;
  logic [3:0] nextTag = '0;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  fpuTop i_fpuTop (
    .clk       (clk),
    .rst       (rst),
    .reqValid  (reqValid),
    .req       (req),
    .reqCredit (reqCredit),
    .resValid  (resValid),
    .res       (res),
    .resCredit (resCredit)
  );

  // Outputs are sampled mid-cycle.
  always @(negedge clk) begin
    if (resValid === 1'b1) begin
      gotQ.push_back(res);
      outstanding++;
    end
    if (resCredit) begin
      outstanding--;
    end
    if (reqCredit === 1'b1) begin
      creditsBack++;
    end
  end

  // Randomly timed credit returns, never more than were consumed.
  always @(posedge clk) begin
    giveBack = returnEnable && (outstanding > 0) && ($random(seed) % 2 == 0);
    #1;
    resCredit = giveBack;
  end

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt > ResetCycles + MarginCycles + CyclesPerReq * sentCnt) begin
      $display("Timeout: %0d cycles passed with %0d requests sent and %0d results received",
               cycleCnt, sentCnt, gotQ.size());
      $display("Verification failed");
      $finish;
    end
  end

  function automatic int inputCredits();
    return `FPU_REQ_DEPTH - sentCnt + creditsBack;
  endfunction

  task automatic checkEq(input string what, input logic [15:0] got, input logic [15:0] want);
    checkCnt++;
    if (got !== want) begin
      errCnt++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  task automatic sendReq(input fpuOp_t op, input logic [15:0] a, input logic [15:0] b,
                         input logic [15:0] expResult, input logic [2:0] expFlags);
    fpuRes_t expected;
    // Hold off until upstream owns a credit.
    while (inputCredits() <= 0) begin
      @(posedge clk);
      #1;
    end
    req.op = op;
    req.a = a;
    req.b = b;
    req.tag = nextTag;
    reqValid = 1'b1;
    expected.result = expResult;
    expected.flags = expFlags;
    expected.tag = nextTag;
    expQ.push_back(expected);
    nextTag = nextTag + 1'b1;
    sentCnt++;
    @(posedge clk);
    #1;
    reqValid = 1'b0;
  endtask

  // Flags are ordered overflow, underflow, inexact.
  task automatic sendVector(input int idx);
    case (idx)
      0:  sendReq(ADD, 16'h3C00, 16'h4000, 16'h4200, 3'b000);
      1:  sendReq(SUB, 16'h4500, 16'h3E00, 16'h4300, 3'b000);
      2:  sendReq(SUB, 16'h3C00, 16'h3C00, 16'h0000, 3'b000);
      3:  sendReq(MUL, 16'h3E00, 16'h4000, 16'h4200, 3'b000);
      4:  sendReq(MUL, 16'hC000, 16'h3800, 16'hBC00, 3'b000);
      // Tie at 2^-11 goes to even.
      5:  sendReq(ADD, 16'h3C00, 16'h1000, 16'h3C00, 3'b001);
      6:  sendReq(ADD, 16'h3C00, 16'h1200, 16'h3C01, 3'b001);
      // 60000 times 2.
      7:  sendReq(MUL, 16'h7B53, 16'h4000, 16'h7C00, 3'b101);
      8:  sendReq(MUL, 16'h0400, 16'h3800, 16'h0200, 3'b010);
      9:  sendReq(ADD, 16'h7C01, 16'h3C00, 16'h7E00, 3'b000);
      10: sendReq(SUB, 16'h7C00, 16'h7C00, 16'h7E00, 3'b000);
      11: sendReq(MUL, 16'h7C00, 16'h0000, 16'h7E00, 3'b000);
      12: sendReq(ADD, 16'h7C00, 16'h3C00, 16'h7C00, 3'b000);
      default: begin
        errCnt++;
        $display("No test vector with index %0d", idx);
      end
    endcase
  endtask

  // Waits for every result sent so far and compares them in order.
  task automatic checkResults();
    fpuRes_t want;
    fpuRes_t got;
    while (gotQ.size() < expQ.size()) begin
      @(posedge clk);
      #1;
    end
    while (checkIdx < expQ.size()) begin
      want = expQ[checkIdx];
      got = gotQ[checkIdx];
      checkEq($sformatf("tag %0d result", want.tag), got.result, want.result);
      checkEq($sformatf("tag %0d flags", want.tag), 16'(got.flags), 16'(want.flags));
      checkEq($sformatf("result %0d tag", checkIdx), 16'(got.tag), 16'(want.tag));
      checkIdx++;
    end
  endtask

  task automatic testAddSub();
    sendVector(0);
    sendVector(1);
    sendVector(2);
    checkResults();
  endtask

  task automatic testMultiply();
    sendVector(3);
    sendVector(4);
    checkResults();
  endtask

  task automatic testRounding();
    sendVector(5);
    sendVector(6);
    sendVector(7);
    sendVector(8);
    checkResults();
  endtask

  task automatic testSpecials();
    sendVector(9);
    sendVector(10);
    sendVector(11);
    sendVector(12);
    checkResults();
  endtask

  task automatic testBackPressure();
    int base;
    int i;
    // Start with every output credit back in the DUT.
    while (outstanding > 0) begin
      @(posedge clk);
      #1;
    end
    returnEnable = 1'b0;
    base = gotQ.size();
    // One result held in SEND plus a full queue behind it.
    for (i = 0; i < `FPU_RES_CREDITS + 1 + `FPU_REQ_DEPTH; i++) begin
      sendVector(i);
    end
    repeat (HoldCycles) @(posedge clk);
    #1;
    checkEq("results without returned credit", 16'(gotQ.size() - base),
            16'(`FPU_RES_CREDITS));
    checkEq("input credits with full queue", 16'(inputCredits()), 16'(0));
    returnEnable = 1'b1;
    checkResults();
  endtask

  task automatic testStreaming();
    int order [10] = '{0, 3, 1, 4, 5, 7, 6, 8, 2, 11};
    int i;
    for (i = 0; i < 10; i++) begin
      sendVector(order[i]);
    end
    checkResults();
    checkEq("reqCredit pulses", 16'(creditsBack), 16'(sentCnt));
  endtask

  initial begin
    rst = 1'b1;
    reqValid = 1'b0;
    req = '0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    returnEnable = 1'b1;
    testAddSub();
    testMultiply();
    testRounding();
    testSpecials();
    testBackPressure();
    testStreaming();
    checkEq("result count", 16'(gotQ.size()), 16'(expQ.size()));
    $display("Summary: %0d checks, %0d errors", checkCnt, errCnt);
    if (errCnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
rtl/fpuPkg.sv
rtl/fpuReqQueue.sv
rtl/fpuCreditCounter.sv
rtl/fpuAddSub.sv
rtl/fpuMulIter.sv
rtl/fpuNormalizer16.sv
rtl/fpuSequencer.sv
rtl/fpuTop.sv
verif/fpuTb.sv

//--- Makefile
# Verilator build and run for the fp16 arithmetic unit.

VERILATOR ?= verilator
TOP       ?= fpuTb
LOG       ?= sim.log
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
